//--- source/dcache_pkg.sv
// dcache package: geometry, address layout and the bus and frame types of the data cache
package dcache_pkg;

   typedef logic [31:0] word_t;

   parameter int WAYS      = 2;
   parameter int SETS      = 8;
   parameter int IDX_W     = 3;
   parameter int BLK_WORDS = 2;
   parameter int TAG_W     = 26;

   // tag | index | word in block | byte in word
   typedef struct packed {
      logic [TAG_W-1:0] tag;
      logic [IDX_W-1:0] idx;
      logic             blkoff;
      logic [1:0]       byteoff;
   } dcache_addr_t;

   // same word seen as a bus address or as cache fields
   typedef union packed {
      word_t        raw;
      dcache_addr_t f;
   } dcache_addr_u;

   typedef struct packed {
      logic                        valid;
      logic                        dirty;
      logic [TAG_W-1:0]            tag;
      word_t [BLK_WORDS-1:0]       data;
   } dcache_frame_t;

   typedef struct packed {
      logic         ren;
      logic         wen;
      logic         halt;
      dcache_addr_u addr;
      word_t        store;
   } dcache_req_t;

   typedef struct packed {
      logic  hit;
      logic  flushed;
      word_t load;
   } dcache_rsp_t;

   typedef struct packed {
      logic  ren;
      logic  wen;
      word_t addr;
      word_t store;
   } mem_req_t;

   typedef struct packed {
      logic  dwait;
      word_t load;
   } mem_rsp_t;

   // one update to one frame, flags may combine
   typedef struct packed {
      logic             way;
      logic [IDX_W-1:0] idx;
      logic             word;
      word_t            data;
      logic             wr_data;     // write data[word]
      logic [TAG_W-1:0] fill_tag;
      logic             set_valid;   // load fill_tag and mark valid
      logic             set_dirty;
      logic             clear_dirty;
   } frame_wr_t;

endpackage

//--- source/dcache_lookup.sv
// dcache lookup: tag compare over both ways, per-set LRU bit and victim choice
`timescale 1ns/1ps

module dcache_lookup (
   input  logic                                             CLK,
   input  logic                                             nRST,
   input  dcache_pkg::dcache_addr_u                         addr,
   input  dcache_pkg::dcache_frame_t [dcache_pkg::WAYS-1:0] frames,
   input  logic                                             lru_touch,
   input  logic                                             touch_way,
   output logic                                             hit,
   output logic                                             hit_way,
   output logic                                             victim_way,
   output logic                                             victim_dirty
);
   import dcache_pkg::*;

   logic [SETS-1:0] lru_q;   // per set, the way to evict next
   logic [WAYS-1:0] match;

   // a way matches only when valid
   always_comb begin
      for (int w = 0; w < WAYS; w++) begin
         match[w] = frames[w].valid && (frames[w].tag == addr.f.tag);
      end
   end

   assign hit     = |match;
   assign hit_way = match[1];   // fills only happen on a miss, so at most one way matches

   // least recently used way of the addressed set
   assign victim_way   = lru_q[addr.f.idx];
   assign victim_dirty = frames[victim_way].valid && frames[victim_way].dirty;

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         lru_q <= '0;   // every set starts pointing at way 0
      end
      else if (lru_touch) begin
         lru_q[addr.f.idx] <= ~touch_way;   // evict the other way next time
      end
   end

endmodule

//--- source/dcache_frames.sv
// dcache frames: valid, dirty, tag and data of every way and set, with two read ports
`timescale 1ns/1ps

module dcache_frames (
   input  logic                                             CLK,
   input  logic                                             nRST,
   input  logic [dcache_pkg::IDX_W-1:0]                     look_idx,
   output dcache_pkg::dcache_frame_t [dcache_pkg::WAYS-1:0] look_frames,
   input  logic [dcache_pkg::IDX_W-1:0]                     ctrl_idx,
   output dcache_pkg::dcache_frame_t [dcache_pkg::WAYS-1:0] ctrl_frames,
   input  logic                                             wr_en,
   input  dcache_pkg::frame_wr_t                            wr
);
   import dcache_pkg::*;

   logic             valid_q [WAYS][SETS];
   logic             dirty_q [WAYS][SETS];
   logic [TAG_W-1:0] tag_q   [WAYS][SETS];
   word_t            data_q  [WAYS][SETS][BLK_WORDS];

   // both ways at each of the two indexes
   always_comb begin
      for (int w = 0; w < WAYS; w++) begin
         look_frames[w].valid = valid_q[w][look_idx];
         look_frames[w].dirty = dirty_q[w][look_idx];
         look_frames[w].tag   = tag_q[w][look_idx];
         ctrl_frames[w].valid = valid_q[w][ctrl_idx];
         ctrl_frames[w].dirty = dirty_q[w][ctrl_idx];
         ctrl_frames[w].tag   = tag_q[w][ctrl_idx];
         for (int b = 0; b < BLK_WORDS; b++) begin
            look_frames[w].data[b] = data_q[w][look_idx][b];
            ctrl_frames[w].data[b] = data_q[w][ctrl_idx][b];
         end
      end
   end

   // state bits of each frame
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         for (int w = 0; w < WAYS; w++) begin
            for (int s = 0; s < SETS; s++) begin
               valid_q[w][s] <= 1'b0;
               dirty_q[w][s] <= 1'b0;
            end
         end
      end
      else if (wr_en) begin
         if (wr.set_valid) begin
            valid_q[wr.way][wr.idx] <= 1'b1;
         end
         if (wr.set_dirty) begin
            dirty_q[wr.way][wr.idx] <= 1'b1;
         end
         else if (wr.clear_dirty) begin
            dirty_q[wr.way][wr.idx] <= 1'b0;
         end
      end
   end

   // tag and block words
   always_ff @(posedge CLK) begin
      if (wr_en) begin
         if (wr.set_valid) begin
            tag_q[wr.way][wr.idx] <= wr.fill_tag;
         end
         if (wr.wr_data) begin
            data_q[wr.way][wr.idx][wr.word] <= wr.data;
         end
      end
   end

endmodule

//--- source/dcache_ctrl.sv
// dcache controller: hit service, miss write-back and fill, and the halt flush walk
`timescale 1ns/1ps

module dcache_ctrl (
   input  logic                                             CLK,
   input  logic                                             nRST,
   input  dcache_pkg::dcache_req_t                          req,
   input  logic                                             hit,
   input  logic                                             hit_way,
   input  logic                                             victim_way,
   input  logic                                             victim_dirty,
   input  dcache_pkg::dcache_frame_t [dcache_pkg::WAYS-1:0] frames,
   output logic [dcache_pkg::IDX_W-1:0]                     frame_idx,
   output logic                                             wr_en,
   output dcache_pkg::frame_wr_t                            wr,
   output logic                                             lru_touch,
   output logic                                             touch_way,
   output dcache_pkg::dcache_rsp_t                          rsp,
   output dcache_pkg::mem_req_t                             mem_out,
   input  dcache_pkg::mem_rsp_t                             mem_in
);
   import dcache_pkg::*;

   typedef enum logic [3:0] {
      idle,
      wback0,
      wback1,
      fill0,
      fill1,
      flush_check,
      flush0,
      flush1,
      stop
   } state_t;

   state_t           state;
   state_t           next_state;
   logic [IDX_W:0]   flush_cnt;        // way in the top bit, set below it
   logic [IDX_W:0]   next_flush_cnt;
   logic             flush_way;
   logic [IDX_W-1:0] flush_set;
   logic             flush_last;
   logic             flushing;
   logic             access;
   dcache_frame_t    victim;
   dcache_frame_t    flush_frame;

   // word address of one word of a block
   function automatic word_t blk_addr(input logic [TAG_W-1:0] tag,
                                      input logic [IDX_W-1:0] idx,
                                      input logic             word);
      dcache_addr_u a;
      a.f.tag     = tag;
      a.f.idx     = idx;
      a.f.blkoff  = word;
      a.f.byteoff = 2'b00;
      return a.raw;
   endfunction

   assign flush_way  = flush_cnt[IDX_W];
   assign flush_set  = flush_cnt[IDX_W-1:0];
   assign flush_last = &flush_cnt;
   assign flushing   = (state == flush_check) || (state == flush0) || (state == flush1);
   assign access     = req.ren || req.wen;

   // the frame port follows the flush walk, otherwise the request
   assign frame_idx   = flushing ? flush_set : req.addr.f.idx;
   assign victim      = frames[victim_way];
   assign flush_frame = frames[flush_way];

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         state     <= idle;
         flush_cnt <= '0;
      end
      else begin
         state     <= next_state;
         flush_cnt <= next_flush_cnt;
      end
   end

   always_comb begin
      next_state     = state;
      next_flush_cnt = flush_cnt;
      rsp            = '0;
      mem_out        = '0;
      wr_en          = 1'b0;
      wr             = '0;
      wr.idx         = frame_idx;
      lru_touch      = 1'b0;
      touch_way      = hit_way;

      case (state)
         idle: begin
            if (req.halt) begin   // halt wins over a pending access
               next_state = flush_check;
            end
            else if (access && hit) begin
               rsp.hit   = 1'b1;
               rsp.load  = frames[hit_way].data[req.addr.f.blkoff];
               lru_touch = 1'b1;
               if (req.wen) begin
                  wr_en        = 1'b1;
                  wr.way       = hit_way;
                  wr.word      = req.addr.f.blkoff;
                  wr.data      = req.store;
                  wr.wr_data   = 1'b1;
                  wr.set_dirty = 1'b1;
               end
            end
            else if (access) begin
               next_state = victim_dirty ? wback0 : fill0;
            end
         end

         wback0: begin
            mem_out.wen   = 1'b1;
            mem_out.addr  = blk_addr(victim.tag, req.addr.f.idx, 1'b0);
            mem_out.store = victim.data[0];
            if (!mem_in.dwait) begin
               next_state = wback1;
            end
         end

         wback1: begin
            mem_out.wen   = 1'b1;
            mem_out.addr  = blk_addr(victim.tag, req.addr.f.idx, 1'b1);
            mem_out.store = victim.data[1];
            if (!mem_in.dwait) begin
               wr_en          = 1'b1;
               wr.way         = victim_way;
               wr.clear_dirty = 1'b1;   // victim now matches memory
               next_state     = fill0;
            end
         end

         fill0: begin
            mem_out.ren  = 1'b1;
            mem_out.addr = blk_addr(req.addr.f.tag, req.addr.f.idx, 1'b0);
            if (!mem_in.dwait) begin
               wr_en      = 1'b1;
               wr.way     = victim_way;
               wr.word    = 1'b0;
               wr.data    = mem_in.load;
               wr.wr_data = 1'b1;
               next_state = fill1;
            end
         end

         fill1: begin
            mem_out.ren  = 1'b1;
            mem_out.addr = blk_addr(req.addr.f.tag, req.addr.f.idx, 1'b1);
            if (!mem_in.dwait) begin
               wr_en          = 1'b1;
               wr.way         = victim_way;
               wr.word        = 1'b1;
               wr.data        = mem_in.load;
               wr.wr_data     = 1'b1;
               wr.fill_tag    = req.addr.f.tag;
               wr.set_valid   = 1'b1;
               wr.clear_dirty = 1'b1;
               next_state     = idle;   // request completes as a hit next cycle
            end
         end

         flush_check: begin
            if (flush_frame.valid && flush_frame.dirty) begin
               next_state = flush0;
            end
            else if (flush_last) begin
               next_state = stop;
            end
            else begin
               next_flush_cnt = flush_cnt + 1'b1;   // clean frame, one cycle
            end
         end

         flush0: begin
            mem_out.wen   = 1'b1;
            mem_out.addr  = blk_addr(flush_frame.tag, flush_set, 1'b0);
            mem_out.store = flush_frame.data[0];
            if (!mem_in.dwait) begin
               next_state = flush1;
            end
         end

         flush1: begin
            mem_out.wen   = 1'b1;
            mem_out.addr  = blk_addr(flush_frame.tag, flush_set, 1'b1);
            mem_out.store = flush_frame.data[1];
            if (!mem_in.dwait) begin
               wr_en          = 1'b1;
               wr.way         = flush_way;
               wr.clear_dirty = 1'b1;
               if (flush_last) begin
                  next_state = stop;
               end
               else begin
                  next_flush_cnt = flush_cnt + 1'b1;
                  next_state     = flush_check;
               end
            end
         end

         stop: begin
            rsp.flushed = 1'b1;   // held until reset
         end

         default: begin
            next_state = idle;
         end
      endcase
   end

endmodule

//--- source/dcache_top.sv
// dcache top: two-way write-back data cache between the processor data port and memory
`timescale 1ns/1ps

module dcache_top (
   input  logic                   CLK,
   input  logic                   nRST,
   input  dcache_pkg::dcache_req_t req,
   output dcache_pkg::dcache_rsp_t rsp,
   output dcache_pkg::mem_req_t    mem_out,
   input  dcache_pkg::mem_rsp_t    mem_in
);
   import dcache_pkg::*;

   dcache_frame_t [WAYS-1:0] look_frames;   // frames at the request index
   dcache_frame_t [WAYS-1:0] ctrl_frames;   // frames at the controller index
   logic [IDX_W-1:0]         ctrl_idx;
   logic                     wr_en;
   frame_wr_t                wr;
   logic                     hit;
   logic                     hit_way;
   logic                     victim_way;
   logic                     victim_dirty;
   logic                     lru_touch;
   logic                     touch_way;

   dcache_lookup u_lookup (
      .CLK          (CLK),
      .nRST         (nRST),
      .addr         (req.addr),
      .frames       (look_frames),
      .lru_touch    (lru_touch),
      .touch_way    (touch_way),
      .hit          (hit),
      .hit_way      (hit_way),
      .victim_way   (victim_way),
      .victim_dirty (victim_dirty)
   );

   dcache_frames u_frames (
      .CLK         (CLK),
      .nRST        (nRST),
      .look_idx    (req.addr.f.idx),
      .look_frames (look_frames),
      .ctrl_idx    (ctrl_idx),
      .ctrl_frames (ctrl_frames),
      .wr_en       (wr_en),
      .wr          (wr)
   );

   dcache_ctrl u_ctrl (
      .CLK          (CLK),
      .nRST         (nRST),
      .req          (req),
      .hit          (hit),
      .hit_way      (hit_way),
      .victim_way   (victim_way),
      .victim_dirty (victim_dirty),
      .frames       (ctrl_frames),
      .frame_idx    (ctrl_idx),
      .wr_en        (wr_en),
      .wr           (wr),
      .lru_touch    (lru_touch),
      .touch_way    (touch_way),
      .rsp          (rsp),
      .mem_out      (mem_out),
      .mem_in       (mem_in)
   );

endmodule

//--- verification/dcache_assertions.sv
// dcache assertions check bus direction, the flushed level and hit gating on the top-level ports
`timescale 1ns/1ps

module dcache_assertions (
   input logic                    CLK,
   input logic                    nRST,
   input dcache_pkg::dcache_rsp_t rsp,
   input dcache_pkg::mem_req_t    mem_out
);

   int fail_count = 0;   // assertion failures so far

   // one direction per memory transfer
   mem_one_dir: assert property (@(posedge CLK) disable iff (!nRST)
      !(mem_out.ren && mem_out.wen))
      else begin
         fail_count++;
         $error("memory read and write requested together");
      end

   flushed_held: assert property (@(posedge CLK) disable iff (!nRST)
      rsp.flushed |=> rsp.flushed)   // only reset clears it
      else begin
         fail_count++;
         $error("flushed dropped before reset");
      end

   no_hit_flushed: assert property (@(posedge CLK) disable iff (!nRST)
      rsp.flushed |-> !rsp.hit)
      else begin
         fail_count++;
         $error("hit reported after the flush");
      end

endmodule

bind dcache_top dcache_assertions u_assertions (
   .CLK     (CLK),
   .nRST    (nRST),
   .rsp     (rsp),
   .mem_out (mem_out)
);

//--- verification/tb_dcache.sv
// dcache testbench with clock, memory model, shadow memory and directed plus random cache traffic
`timescale 1ns/1ps

module tb_dcache;
   import dcache_pkg::*;

   localparam int MEM_WORDS     = 256;   // model window covers byte addresses below 0x400
   localparam int HIT_TIMEOUT   = 200;
   localparam int FLUSH_TIMEOUT = 2000;

   logic        CLK;
   logic        nRST;
   dcache_req_t req;
   dcache_rsp_t rsp;
   mem_req_t    mem_out;
   mem_rsp_t    mem_in;

   word_t  mem_model [MEM_WORDS];
   word_t  shadow    [MEM_WORDS];
   int     rd_count;
   int     wr_count;
   integer seed      = 32'h9e7a;
   logic   mem_busy  = 1'b0;
   int     wait_left = 0;

   dcache_top u_dcache_top (
      .CLK     (CLK),
      .nRST    (nRST),
      .req     (req),
      .rsp     (rsp),
      .mem_out (mem_out),
      .mem_in  (mem_in)
   );

   initial begin
      CLK = 1'b0;
      forever #20 CLK = ~CLK;
   end

   // reference memory contents are the word address xor a constant
   function automatic word_t mem_init(input word_t addr);
      return {2'b00, addr[31:2]} ^ 32'h5ca1_0f3d;
   endfunction

   function automatic int word_index(input word_t addr);
      return int'(addr[9:2]);
   endfunction

   function automatic word_t expect_load(input word_t addr);
      return shadow[word_index(addr)];
   endfunction

   // tag from bit 6 up with the set index in bits 5..3 and the block word at bit 2
   function automatic word_t mk_addr(input int tag, input int idx, input int word);
      return word_t'((tag << 6) | (idx << 3) | (word << 2));
   endfunction

   task automatic fail_stop(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      $display("tests failed");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_load(input word_t got, input word_t exp, input string what);
      if (got !== exp) begin
         fail_stop($sformatf("%s got %h expected %h", what, got, exp));
      end
   endtask

   task automatic check_flag(input logic ok, input string what);
      if (ok !== 1'b1) begin
         fail_stop($sformatf("%s does not hold", what));
      end
   endtask

   task automatic wait_hit();
      int cycles;
      cycles = 0;
      @(negedge CLK);
      while (!rsp.hit) begin
         if (cycles == HIT_TIMEOUT) begin
            fail_stop("cache never answered the request before the timeout");
         end
         cycles++;
         @(negedge CLK);
      end
   endtask

   task automatic flush_wait();
      int cycles;
      cycles = 0;
      @(negedge CLK);
      while (!rsp.flushed) begin
         if (cycles == FLUSH_TIMEOUT) begin
            fail_stop("cache never reported flushed before the timeout");
         end
         cycles++;
         @(negedge CLK);
      end
   endtask

   // request held until hit and dropped on the following edge
   task automatic read_word(input word_t addr);
      @(posedge CLK);
      req.ren      <= 1'b1;
      req.addr.raw <= addr;
      wait_hit();
      @(posedge CLK);
      req.ren <= 1'b0;
   endtask

   task automatic write_word(input word_t addr, input word_t data);
      @(posedge CLK);
      req.wen      <= 1'b1;
      req.addr.raw <= addr;
      req.store    <= data;
      wait_hit();
      shadow[word_index(addr)] = data;
      @(posedge CLK);
      req.wen <= 1'b0;
   endtask

   // memory and shadow restart from mem_init along with the DUT
   task automatic apply_reset();
      @(posedge CLK);
      nRST <= 1'b0;
      req  <= '0;
      for (int k = 0; k < MEM_WORDS; k++) begin
         mem_model[k] = mem_init(word_t'(k << 2));
         shadow[k]    = mem_init(word_t'(k << 2));
      end
      rd_count = 0;
      wr_count = 0;
      repeat (3) @(posedge CLK);
      nRST <= 1'b1;
      @(negedge CLK);
      check_flag(!rsp.hit && !rsp.flushed && !mem_out.ren && !mem_out.wen,
                 "all outputs low after reset");
   endtask

   // memory model with 0 to 3 wait cycles per word
   always @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         mem_in.dwait <= 1'b1;
         mem_in.load  <= '0;
         mem_busy     = 1'b0;
         wait_left    = 0;
      end
      else if (!mem_in.dwait) begin   // word transfer completes at this edge
         if (mem_out.wen) begin
            mem_model[word_index(mem_out.addr)] = mem_out.store;
            wr_count++;
         end
         else begin
            rd_count++;
         end
         mem_in.dwait <= 1'b1;
         mem_busy     = 1'b0;
      end
      else if (mem_out.ren || mem_out.wen) begin
         if (!mem_busy) begin
            check_flag(mem_out.addr < MEM_WORDS * 4, "memory address inside the model window");
            mem_busy  = 1'b1;
            wait_left = $random(seed) & 3;
         end
         if (wait_left == 0) begin
            mem_in.dwait <= 1'b0;
            mem_in.load  <= mem_model[word_index(mem_out.addr)];
         end
         else begin
            wait_left--;
         end
      end
   end

   // every read hit is compared with the shadow
   always @(negedge CLK) begin
      if (u_dcache_top.u_assertions.fail_count != 0) begin
         fail_stop("a concurrent assertion on the cache ports failed");
      end
      if (nRST && rsp.hit && req.ren) begin
         check_load(rsp.load, expect_load(req.addr.raw), "read data");
      end
   end

   initial begin
      int          rd_before;
      int          wr_before;
      int          idx;
      int          sel;
      int          wsel;
      word_t       addr;
      logic [15:0] dirty_blk;   // one bit per (tag, set) written in the random phase

      nRST   = 1'b0;
      req    = '0;
      mem_in = '0;
      mem_in.dwait = 1'b1;
      apply_reset();

      // cold read fetches the block and its other word is then resident
      read_word(mk_addr(1, 2, 0));
      check_flag(rd_count == 2 && wr_count == 0, "cold read makes two memory reads");
      read_word(mk_addr(1, 2, 1));
      check_flag(rd_count == 2, "second word of the block reads without traffic");

      // write hit then write miss
      write_word(mk_addr(1, 2, 1), 32'h1234_5678);
      read_word(mk_addr(1, 2, 1));
      check_flag(rd_count == 2 && wr_count == 0, "write hit and read back without traffic");
      write_word(mk_addr(2, 5, 0), 32'hcafe_f00d);
      rd_before = rd_count;
      read_word(mk_addr(2, 5, 0));
      check_flag(rd_count == rd_before, "read after write miss stays in the cache");

      // LRU in set 4
      read_word(mk_addr(3, 4, 0));
      read_word(mk_addr(4, 4, 0));
      read_word(mk_addr(3, 4, 0));
      read_word(mk_addr(5, 4, 0));   // evicts tag 4
      rd_before = rd_count;
      read_word(mk_addr(3, 4, 0));
      check_flag(rd_count == rd_before, "recently used block kept");
      read_word(mk_addr(4, 4, 0));
      check_flag(rd_count == rd_before + 2, "least recently used block evicted");

      // dirty evictions in set 6
      write_word(mk_addr(3, 6, 0), 32'hdead_0a0a);
      write_word(mk_addr(4, 6, 1), 32'hbeef_0b0b);
      wr_before = wr_count;
      read_word(mk_addr(5, 6, 0));
      check_flag(wr_count == wr_before + 2, "first dirty victim written back");
      wr_before = wr_count;
      read_word(mk_addr(6, 6, 0));
      check_flag(wr_count == wr_before + 2, "second dirty victim written back");
      read_word(mk_addr(3, 6, 0));
      read_word(mk_addr(4, 6, 1));

      // random traffic on two tags per set so nothing is ever evicted
      apply_reset();
      dirty_blk = '0;
      for (int i = 0; i < 48; i++) begin
         idx  = $random(seed) & 7;
         sel  = $random(seed) & 1;
         wsel = $random(seed) & 1;
         addr = mk_addr(8 + sel, idx, wsel);
         if ($random(seed) & 1) begin
            write_word(addr, $random(seed));
            dirty_blk[sel * 8 + idx] = 1'b1;
         end
         else begin
            read_word(addr);
         end
      end
      check_flag(wr_count == 0, "no write-back while every block stays resident");

      @(posedge CLK);
      req.halt <= 1'b1;
      flush_wait();
      check_flag(wr_count == 2 * $countones(dirty_blk), "flush writes two words per dirty block");
      for (int k = 0; k < MEM_WORDS; k++) begin
         check_load(mem_model[k], shadow[k], $sformatf("memory word %0d after flush", k));
      end
      repeat (3) @(negedge CLK);
      check_flag(rsp.flushed, "flushed level held");

      if (u_dcache_top.u_assertions.fail_count == 0) begin
         $display("all tests passed");
         $finish;
      end
      else begin
         fail_stop("a concurrent assertion on the cache ports failed");
      end
   end

endmodule

//--- compile.f
source/dcache_pkg.sv
source/dcache_lookup.sv
source/dcache_frames.sv
source/dcache_ctrl.sv
source/dcache_top.sv
verification/dcache_assertions.sv
verification/tb_dcache.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - source/dcache_pkg.sv
  - source/dcache_lookup.sv
  - source/dcache_frames.sv
  - source/dcache_ctrl.sv
  - source/dcache_top.sv
  - target: simulation
    files:
      - verification/dcache_assertions.sv
      - verification/tb_dcache.sv
